// ==== rolly_pkg.sv ====
// shared widths, sizes and packet formats for the two-port load/store front end
// every rtl file refers to these by scoped name, so compile this file first
package rolly_pkg;

  localparam int NUM_PORTS   = 2;
  localparam int WORD_WIDTH  = 32;
  localparam int PADDR_WIDTH = 10;
  localparam int BLOCK_WORDS = 4;
  localparam int SETS        = 16;
  localparam int FIFO_ELS    = 8;
  localparam int MEM_LATENCY = 4;

  // derived field widths
  localparam int OFFSET_WIDTH = $clog2(BLOCK_WORDS);
  localparam int INDEX_WIDTH  = $clog2(SETS);
  localparam int TAG_WIDTH    = PADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int PTR_WIDTH    = $clog2(FIFO_ELS) + 1;
  localparam int LAT_WIDTH    = $clog2(MEM_LATENCY + 1);
  localparam int PORT_WIDTH   = $clog2(NUM_PORTS);

  typedef logic [PADDR_WIDTH-1:0]  paddr_t;
  typedef logic [WORD_WIDTH-1:0]   word_t;
  typedef logic [OFFSET_WIDTH-1:0] offset_t;
  typedef logic [INDEX_WIDTH-1:0]  index_t;
  typedef logic [TAG_WIDTH-1:0]    tag_t;
  typedef logic [PTR_WIDTH-1:0]    ptr_t;
  typedef logic [LAT_WIDTH-1:0]    lat_cnt_t;
  typedef logic [PORT_WIDTH-1:0]   port_id_t;

  typedef enum logic [0:0] {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } op_e;

  // one memory operation as it enters a port
  typedef struct packed {
    op_e    op;
    paddr_t addr;
    word_t  data;
  } dcache_pkt_s;

  // word address split for the direct-mapped cache
  typedef struct packed {
    tag_t    tag;
    index_t  index;
    offset_t offset;
  } addr_fields_s;

  typedef logic [BLOCK_WORDS-1:0][WORD_WIDTH-1:0] block_t;

  // write: word address and store word
  // read: block-aligned address, data unused
  typedef struct packed {
    logic   write;
    paddr_t addr;
    word_t  data;
  } mem_req_s;

endpackage

// ==== rolly_fifo.sv ====
`timescale 1ns/100ps
// per-port operation queue in front of the data cache
// entries stay until the cache retires them, so a miss can rewind the
// read pointer to the oldest uncommitted operation and replay from there
module rolly_fifo (
  input  logic                   clk_i
  , input  logic                   reset_i

  , input  rolly_pkg::dcache_pkt_s pkt_i
  , input  logic                   pkt_v_i
  , output logic                   pkt_ready_o

  , output rolly_pkg::dcache_pkt_s pkt_o
  , output logic                   pkt_v_o
  , input  logic                   pkt_yumi_i

  , input  logic                   ckpt_i
  , input  logic                   roll_i
);

  rolly_pkg::ptr_t wptr_r;
  rolly_pkg::ptr_t rptr_r;
  rolly_pkg::ptr_t cptr_r;
  rolly_pkg::ptr_t cptr_next;
  rolly_pkg::ptr_t used;
  logic            push;

  rolly_pkg::dcache_pkt_s mem_r [rolly_pkg::FIFO_ELS];

  // entries held from the checkpoint on, replayable ones included
  assign used        = wptr_r - cptr_r;
  assign pkt_ready_o = (used != rolly_pkg::ptr_t'(rolly_pkg::FIFO_ELS));
  assign push        = pkt_v_i & pkt_ready_o;

  assign pkt_v_o = (rptr_r != wptr_r);
  assign pkt_o   = mem_r[rptr_r[rolly_pkg::PTR_WIDTH-2:0]];

  assign cptr_next = cptr_r + rolly_pkg::ptr_t'(ckpt_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r <= '0;
      rptr_r <= '0;
      cptr_r <= '0;
    end else begin
      cptr_r <= cptr_next;
      if (push) begin
        wptr_r <= wptr_r + 1'b1;
      end
      // rewind to the oldest operation not yet retired
      if (roll_i) begin
        rptr_r <= cptr_next;
      end else if (pkt_yumi_i) begin
        rptr_r <= rptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wptr_r[rolly_pkg::PTR_WIDTH-2:0]] <= pkt_i;
    end
  end

  // the cache holds ready low while it flags a miss
  a_no_roll_with_pop: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(roll_i && pkt_yumi_i)
  );

  // retired entries are always ones already read out
  a_ckpt_behind_read: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rolly_pkg::ptr_t'(rptr_r - cptr_r) <= used
  );

endmodule

// ==== rolly_dcache.sv ====
`timescale 1ns/100ps
// two-stage blocking data cache, direct-mapped and write-through
// stage 1 reads the arrays, stage 2 checks the tag and completes the operation
// a load miss flags miss_o, drops the pipeline and waits for the block fill
module rolly_dcache (
  input  logic                   clk_i
  , input  logic                   reset_i

  , input  rolly_pkg::dcache_pkt_s pkt_i
  , input  logic                   pkt_v_i
  , output logic                   ready_o

  , output logic                   load_v_o
  , output rolly_pkg::word_t       load_data_o
  , output logic                   retire_o
  , output logic                   miss_o

  , output rolly_pkg::mem_req_s    mem_req_o
  , output logic                   mem_req_v_o
  , input  logic                   mem_req_ready_i

  , input  logic                   mem_resp_v_i
  , input  rolly_pkg::block_t      mem_resp_data_i
);

  typedef enum logic [1:0] {
    S_RUN,
    S_FILL_REQ,
    S_FILL_WAIT
  } state_e;

  state_e state_r;

  logic [rolly_pkg::SETS-1:0] valid_r;
  rolly_pkg::tag_t            tag_r  [rolly_pkg::SETS];
  rolly_pkg::block_t          data_r [rolly_pkg::SETS];

  logic                    s1_v_r;
  rolly_pkg::dcache_pkt_s  s1_pkt_r;
  rolly_pkg::addr_fields_s s1_addr;

  logic                    s2_v_r;
  rolly_pkg::dcache_pkt_s  s2_pkt_r;
  rolly_pkg::addr_fields_s s2_addr;
  logic                    s2_valid_r;
  rolly_pkg::tag_t         s2_tag_r;
  rolly_pkg::block_t       s2_block_r;

  logic s2_hit;
  logic s2_load;
  logic s2_store;
  logic s2_done;
  logic advance;
  logic store_wr;

  rolly_pkg::block_t       store_block;
  rolly_pkg::paddr_t       fill_addr_r;
  rolly_pkg::addr_fields_s fill_addr;

  assign s1_addr   = rolly_pkg::addr_fields_s'(s1_pkt_r.addr);
  assign s2_addr   = rolly_pkg::addr_fields_s'(s2_pkt_r.addr);
  assign fill_addr = rolly_pkg::addr_fields_s'(fill_addr_r);

  assign s2_hit   = s2_valid_r && (s2_tag_r == s2_addr.tag);
  assign s2_load  = s2_v_r && (s2_pkt_r.op == rolly_pkg::OP_LOAD);
  assign s2_store = s2_v_r && (s2_pkt_r.op == rolly_pkg::OP_STORE);

  // stores hold stage 2 until the write-through is taken
  assign s2_done  = !s2_v_r || (s2_load && s2_hit) || (s2_store && mem_req_ready_i);
  assign advance  = (state_r == S_RUN) && s2_done;
  assign ready_o  = advance;

  assign miss_o      = (state_r == S_RUN) && s2_load && !s2_hit;
  assign load_v_o    = (state_r == S_RUN) && s2_load && s2_hit;
  assign load_data_o = s2_block_r[s2_addr.offset];
  assign retire_o    = load_v_o || (s2_store && mem_req_ready_i);

  // no allocate on a store miss
  assign store_wr = s2_store && mem_req_ready_i && s2_hit;

  always_comb begin
    store_block = s2_block_r;
    store_block[s2_addr.offset] = s2_pkt_r.data;
  end

  always_comb begin
    mem_req_v_o = s2_store || (state_r == S_FILL_REQ);
    if (state_r == S_FILL_REQ) begin
      mem_req_o.write = 1'b0;
      mem_req_o.addr  = {fill_addr.tag, fill_addr.index, rolly_pkg::offset_t'(0)};
      mem_req_o.data  = '0;
    end else begin
      mem_req_o.write = 1'b1;
      mem_req_o.addr  = s2_pkt_r.addr;
      mem_req_o.data  = s2_pkt_r.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= S_RUN;
      s1_v_r  <= 1'b0;
      s2_v_r  <= 1'b0;
      valid_r <= '0;
    end else begin
      case (state_r)
        S_RUN: begin
          if (miss_o) begin
            // poison both stages so the fifo replays them
            state_r <= S_FILL_REQ;
            s1_v_r  <= 1'b0;
            s2_v_r  <= 1'b0;
          end else if (advance) begin
            s1_v_r <= pkt_v_i;
            s2_v_r <= s1_v_r;
          end
        end
        S_FILL_REQ: begin
          if (mem_req_ready_i) begin
            state_r <= S_FILL_WAIT;
          end
        end
        default: begin
          if (mem_resp_v_i) begin
            state_r <= S_RUN;
            valid_r[fill_addr.index] <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      s1_pkt_r   <= pkt_i;
      s2_pkt_r   <= s1_pkt_r;
      s2_valid_r <= valid_r[s1_addr.index];
      s2_tag_r   <= tag_r[s1_addr.index];
      // forward a store hit to the same set
      if (store_wr && (s2_addr.index == s1_addr.index)) begin
        s2_block_r <= store_block;
      end else begin
        s2_block_r <= data_r[s1_addr.index];
      end
    end
    if (miss_o) begin
      fill_addr_r <= s2_pkt_r.addr;
    end
    if (store_wr) begin
      data_r[s2_addr.index] <= store_block;
    end else if ((state_r == S_FILL_WAIT) && mem_resp_v_i) begin
      tag_r[fill_addr.index]  <= fill_addr.tag;
      data_r[fill_addr.index] <= mem_resp_data_i;
    end
  end

  // the memory end only answers fill reads
  a_resp_in_fill_wait: assert property (
    @(posedge clk_i) disable iff (reset_i)
    mem_resp_v_i |-> (state_r == S_FILL_WAIT)
  );

  // a request waiting for the memory end keeps its contents
  a_req_held: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (mem_req_v_o && !mem_req_ready_i) |=> (mem_req_v_o && $stable(mem_req_o))
  );

endmodule

// ==== rolly_mem_end.sv ====
`timescale 1ns/100ps
// shared memory end for all ports
// round-robin grant of one request per cycle, writes update one word at once,
// reads return the aligned block a fixed number of cycles after the grant
module rolly_mem_end (
  input  logic                                            clk_i
  , input  logic                                            reset_i

  , input  rolly_pkg::mem_req_s [rolly_pkg::NUM_PORTS-1:0] req_i
  , input  logic [rolly_pkg::NUM_PORTS-1:0]                req_v_i
  , output logic [rolly_pkg::NUM_PORTS-1:0]                req_ready_o

  , output logic [rolly_pkg::NUM_PORTS-1:0]                resp_v_o
  , output rolly_pkg::block_t [rolly_pkg::NUM_PORTS-1:0]   resp_data_o
);

  rolly_pkg::word_t mem_r [2**rolly_pkg::PADDR_WIDTH];

  rolly_pkg::lat_cnt_t [rolly_pkg::NUM_PORTS-1:0] cnt_r;
  rolly_pkg::paddr_t   [rolly_pkg::NUM_PORTS-1:0] rd_addr_r;
  rolly_pkg::port_id_t                            last_r;

  logic [rolly_pkg::NUM_PORTS-1:0] busy;
  logic [rolly_pkg::NUM_PORTS-1:0] elig;
  logic [rolly_pkg::NUM_PORTS-1:0] grant;
  rolly_pkg::port_id_t             grant_id;
  rolly_pkg::mem_req_s             win;

  for (genvar p = 0; p < rolly_pkg::NUM_PORTS; p++) begin : g_port
    assign busy[p]     = (cnt_r[p] != '0);
    assign resp_v_o[p] = (cnt_r[p] == rolly_pkg::lat_cnt_t'(1));

    // one read in flight per port
    a_resp_outstanding: assert property (
      @(posedge clk_i) disable iff (reset_i)
      resp_v_o[p] |-> $past(req_v_i[p] && req_ready_o[p] && !req_i[p].write,
                            rolly_pkg::MEM_LATENCY)
    );
  end

  assign elig        = req_v_i & ~busy;
  assign req_ready_o = grant;
  assign win         = req_i[grant_id];

  // search starts just after the last winner
  always_comb begin
    int idx;
    grant    = '0;
    grant_id = last_r;
    for (int k = 1; k <= rolly_pkg::NUM_PORTS; k++) begin
      idx = (int'(last_r) + k) % rolly_pkg::NUM_PORTS;
      if ((grant == '0) && elig[idx]) begin
        grant[idx] = 1'b1;
        grant_id   = rolly_pkg::port_id_t'(idx);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_r <= '0;
      cnt_r  <= '0;
    end else begin
      if (|grant) begin
        last_r <= grant_id;
      end
      for (int p = 0; p < rolly_pkg::NUM_PORTS; p++) begin
        if (grant[p] && !req_i[p].write) begin
          cnt_r[p] <= rolly_pkg::lat_cnt_t'(rolly_pkg::MEM_LATENCY);
        end else if (busy[p]) begin
          cnt_r[p] <= cnt_r[p] - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((|grant) && win.write) begin
      mem_r[win.addr] <= win.data;
    end
    for (int p = 0; p < rolly_pkg::NUM_PORTS; p++) begin
      if (grant[p]) begin
        rd_addr_r[p] <= req_i[p].addr;
      end
    end
  end

  // block read at response time
  always_comb begin
    for (int p = 0; p < rolly_pkg::NUM_PORTS; p++) begin
      for (int w = 0; w < rolly_pkg::BLOCK_WORDS; w++) begin
        resp_data_o[p][w] = mem_r[{rd_addr_r[p][rolly_pkg::PADDR_WIDTH-1:rolly_pkg::OFFSET_WIDTH],
                                   rolly_pkg::offset_t'(w)}];
      end
    end
  end

endmodule

// ==== rolly_top.sv ====
`timescale 1ns/100ps
// two-port load/store front end with miss replay
// each port is a rollback fifo feeding a blocking data cache,
// and both caches share one memory end
module rolly_top (
  input  logic                                              clk_i
  , input  logic                                              reset_i

  , input  rolly_pkg::dcache_pkt_s [rolly_pkg::NUM_PORTS-1:0] pkt_i
  , input  logic [rolly_pkg::NUM_PORTS-1:0]                   pkt_v_i
  , output logic [rolly_pkg::NUM_PORTS-1:0]                   pkt_ready_o

  , output logic [rolly_pkg::NUM_PORTS-1:0]                   load_v_o
  , output rolly_pkg::word_t [rolly_pkg::NUM_PORTS-1:0]       load_data_o
);

  rolly_pkg::dcache_pkt_s [rolly_pkg::NUM_PORTS-1:0] fifo_pkt;
  logic [rolly_pkg::NUM_PORTS-1:0] fifo_v;
  logic [rolly_pkg::NUM_PORTS-1:0] cache_ready;
  logic [rolly_pkg::NUM_PORTS-1:0] yumi;
  logic [rolly_pkg::NUM_PORTS-1:0] retire;
  logic [rolly_pkg::NUM_PORTS-1:0] miss;

  rolly_pkg::mem_req_s [rolly_pkg::NUM_PORTS-1:0] mem_req;
  logic [rolly_pkg::NUM_PORTS-1:0] mem_req_v;
  logic [rolly_pkg::NUM_PORTS-1:0] mem_req_ready;
  logic [rolly_pkg::NUM_PORTS-1:0] mem_resp_v;
  rolly_pkg::block_t [rolly_pkg::NUM_PORTS-1:0] mem_resp_data;

  for (genvar i = 0; i < rolly_pkg::NUM_PORTS; i++) begin : g_port
    assign yumi[i] = fifo_v[i] & cache_ready[i];

    rolly_fifo fifo (
      .clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.pkt_i(pkt_i[i])
      ,.pkt_v_i(pkt_v_i[i])
      ,.pkt_ready_o(pkt_ready_o[i])
      ,.pkt_o(fifo_pkt[i])
      ,.pkt_v_o(fifo_v[i])
      ,.pkt_yumi_i(yumi[i])
      ,.ckpt_i(retire[i])
      ,.roll_i(miss[i])
    );

    rolly_dcache dcache (
      .clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.pkt_i(fifo_pkt[i])
      ,.pkt_v_i(fifo_v[i])
      ,.ready_o(cache_ready[i])
      ,.load_v_o(load_v_o[i])
      ,.load_data_o(load_data_o[i])
      ,.retire_o(retire[i])
      ,.miss_o(miss[i])
      ,.mem_req_o(mem_req[i])
      ,.mem_req_v_o(mem_req_v[i])
      ,.mem_req_ready_i(mem_req_ready[i])
      ,.mem_resp_v_i(mem_resp_v[i])
      ,.mem_resp_data_i(mem_resp_data[i])
    );
  end

  rolly_mem_end me (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.req_i(mem_req)
    ,.req_v_i(mem_req_v)
    ,.req_ready_o(mem_req_ready)
    ,.resp_v_o(mem_resp_v)
    ,.resp_data_o(mem_resp_data)
  );

endmodule

// ==== tb_rolly_top.sv ====
`timescale 1ns/100ps
// testbench for the two-port load/store front end
// reads operations and expected load values from rolly_stimulus.txt,
// drives each port from its own process and checks every load result in order
module tb_rolly_top;

  localparam int NP            = rolly_pkg::NUM_PORTS;
  localparam int RESET_CYCLES  = 10;
  localparam int SETTLE_CYCLES = 20;
  localparam int CYCLES_PER_OP = (rolly_pkg::FIFO_ELS + rolly_pkg::MEM_LATENCY + 8) * 2;

  typedef struct packed {
    rolly_pkg::dcache_pkt_s pkt;
    rolly_pkg::word_t       exp;
    logic [2:0]             gap;
  } op_rec_s;

  logic                            clk;
  logic                            reset;
  rolly_pkg::dcache_pkt_s [NP-1:0] pkt;
  logic [NP-1:0]                   pkt_v;
  logic [NP-1:0]                   pkt_ready;
  logic [NP-1:0]                   load_v;
  rolly_pkg::word_t [NP-1:0]       load_data;

  op_rec_s       ops_q [NP][$];
  int            seed;
  int            total_ops;
  int            main_errors;
  logic          loaded;
  logic          reset_done;
  logic          finishing;
  logic [NP-1:0] drive_done;
  int            pending [NP];
  int            port_errors [NP];
  int            port_stalls [NP];

  rolly_top DUT (
    .clk_i(clk)
    ,.reset_i(reset)
    ,.pkt_i(pkt)
    ,.pkt_v_i(pkt_v)
    ,.pkt_ready_o(pkt_ready)
    ,.load_v_o(load_v)
    ,.load_data_o(load_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // mostly back to back, so a miss lets the fifo fill up
  function automatic logic [2:0] pick_gap();
    logic [31:0] r;
    r = $random(seed);
    if (r[3:0] < 4'd11) begin
      return 3'd0;
    end
    return {1'b0, r[5:4]} + 3'd1;
  endfunction

  function automatic int total_pending();
    int sum;
    sum = 0;
    for (int p = 0; p < NP; p++) begin
      sum += pending[p];
    end
    return sum;
  endfunction

  function automatic int total_errors();
    int sum;
    sum = main_errors;
    for (int p = 0; p < NP; p++) begin
      sum += port_errors[p];
    end
    return sum;
  endfunction

  task automatic report_counts();
    $display("errors %0d, missing results %0d", total_errors(), total_pending());
  endtask

  for (genvar p = 0; p < NP; p++) begin : g_port
    rolly_pkg::dcache_pkt_s drv_pkt;
    logic                   drv_v;
    logic                   done;
    op_rec_s                exp_q [$];
    int                     pushed;
    int                     stalls;
    int                     seen = 0;
    int                     errors = 0;

    assign pkt[p]         = drv_pkt;
    assign pkt_v[p]       = drv_v;
    assign drive_done[p]  = done;
    assign pending[p]     = pushed - seen;
    assign port_errors[p] = errors;
    assign port_stalls[p] = stalls;

    initial begin : drive
      op_rec_s rec;
      drv_pkt = '0;
      drv_v   = 1'b0;
      done    = 1'b0;
      pushed  = 0;
      stalls  = 0;
      wait (loaded && reset_done);
      for (int i = 0; i < ops_q[p].size(); i++) begin
        rec = ops_q[p][i];
        repeat (rec.gap) @(negedge clk);
        drv_pkt = rec.pkt;
        drv_v   = 1'b1;
        while (!pkt_ready[p]) begin
          stalls++;
          @(negedge clk);
        end
        if (rec.pkt.op == rolly_pkg::OP_LOAD) begin
          exp_q.push_back(rec);
          pushed++;
        end
        @(negedge clk);
        drv_v = 1'b0;
      end
      done = 1'b1;
    end

    // results come back in request order per port
    always @(negedge clk) begin : check
      op_rec_s want;
      if (!reset && load_v[p]) begin
        assert (seen < exp_q.size()) else begin
          errors++;
          $display("port %0d returned a load result at %0t with no load outstanding",
                   p, $time);
        end
        if (seen < exp_q.size()) begin
          want = exp_q[seen];
          seen++;
          assert (load_data[p] == want.exp) else begin
            errors++;
            $display("ERROR %0t: port %0d load from %h returned %h, expected %h",
                     $time, p, want.pkt.addr, load_data[p], want.exp);
          end
        end
      end
    end
  end

  initial begin : main
    int    fd;
    int    n;
    int    port;
    int    op;
    int    addr;
    int    data;
    int    exp;
    string line;
    op_rec_s rec;
    reset        = 1'b1;
    loaded       = 1'b0;
    reset_done   = 1'b0;
    finishing    = 1'b0;
    main_errors  = 0;
    total_ops    = 0;
    seed         = 17383;
    fd = $fopen("rolly_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file rolly_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%h %h %h %h %h", port, op, addr, data, exp);
        if (n == 5 && port >= 0 && port < NP) begin
          rec.pkt.op   = rolly_pkg::op_e'(op[0]);
          rec.pkt.addr = rolly_pkg::paddr_t'(addr);
          rec.pkt.data = rolly_pkg::word_t'(data);
          rec.exp      = rolly_pkg::word_t'(exp);
          rec.gap      = pick_gap();
          ops_q[port].push_back(rec);
          total_ops++;
        end
      end
      $fclose(fd);
    end
    if (total_ops == 0) begin
      $display("no operations were read from the stimulus file");
    end
    loaded = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset      = 1'b0;
    reset_done = 1'b1;
    assert (pkt_ready == '1) else begin
      main_errors++;
      $display("pkt_ready_o is not high on every port after reset");
    end
    assert (load_v == '0) else begin
      main_errors++;
      $display("load_v_o is high right after reset");
    end

    while (drive_done != '1 || total_pending() != 0) begin
      @(negedge clk);
    end
    // late duplicates would show up here
    repeat (SETTLE_CYCLES) @(negedge clk);

    finishing = 1'b1;
    // every port must have been held off by a full fifo at least once
    for (int p = 0; p < NP; p++) begin
      assert (port_stalls[p] > 0) else begin
        main_errors++;
        $display("pkt_ready_o of port %0d never dropped, its fifo never filled", p);
      end
    end
    report_counts();
    if (total_errors() == 0 && total_pending() == 0 && total_ops > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = RESET_CYCLES + 2 * SETTLE_CYCLES + total_ops * CYCLES_PER_OP;
    repeat (limit) @(posedge clk);
    if (!finishing) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      report_counts();
      $display("TEST FAIL");
      $finish;
    end
  end

endmodule

// ==== rolly_stimulus.txt ====
# port op addr store_data expected_load, all hex; op 1 is a store, op 0 is a load
# store_data is unused for loads, expected_load is unused for stores
# port 0: store then load, write-through hit, miss burst, set conflict
0 1 010 a0000010 00000000
0 0 010 00000000 a0000010
0 1 010 a1000010 00000000
0 0 010 00000000 a1000010
0 1 020 a0000020 00000000
0 1 021 a0000021 00000000
0 1 022 a0000022 00000000
0 1 023 a0000023 00000000
0 1 044 a0000044 00000000
0 1 048 a0000048 00000000
0 0 020 00000000 a0000020
0 0 021 00000000 a0000021
0 0 044 00000000 a0000044
0 0 022 00000000 a0000022
0 0 048 00000000 a0000048
0 0 023 00000000 a0000023
0 1 110 a0000110 00000000
0 0 110 00000000 a0000110
0 0 010 00000000 a1000010
0 1 011 a0000011 00000000
0 0 011 00000000 a0000011
0 0 110 00000000 a0000110
0 1 1fc a00001fc 00000000
0 0 1fc 00000000 a00001fc
# port 1: store misses, load burst across blocks, hit update, set conflict
1 1 200 b0000200 00000000
1 1 201 b0000201 00000000
1 1 204 b0000204 00000000
1 1 208 b0000208 00000000
1 1 20c b000020c 00000000
1 1 210 b0000210 00000000
1 0 200 00000000 b0000200
1 0 204 00000000 b0000204
1 0 208 00000000 b0000208
1 0 20c 00000000 b000020c
1 0 210 00000000 b0000210
1 0 201 00000000 b0000201
1 0 204 00000000 b0000204
1 1 204 b1000204 00000000
1 0 204 00000000 b1000204
1 0 200 00000000 b0000200
1 1 300 b0000300 00000000
1 0 300 00000000 b0000300
1 0 200 00000000 b0000200
1 0 201 00000000 b0000201
1 1 3ff b00003ff 00000000
1 0 3ff 00000000 b00003ff
1 0 20c 00000000 b000020c

// ==== sources.f ====
rolly_pkg.sv
rolly_fifo.sv
rolly_dcache.sv
rolly_mem_end.sv
rolly_top.sv
tb_rolly_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rolly_top
RTL_TOP   ?= rolly_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= TEST PASS

RTL_SRCS = $(filter-out tb_%,$(shell cat $(FILELIST)))
SIM      = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
